// ==== flist.f ====
emu_remap_pkg.sv
remap_req_if.sv
remap_ctrl.sv
req_fifo.sv
mem_window.sv
emu_remap_top.sv
remap_properties.sv
remap_checker.sv
tb_emu_remap.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_emu_remap
FLIST    ?= flist.f
OUTDIR   ?= obj_dir
LOG      ?= sim.log
SIMFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OUTDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OUTDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OUTDIR) $(LOG)

// ==== tb_emu_remap.sv ====
`timescale 1ns/1ps

module tb_emu_remap;

    localparam int ADDR_WIDTH = 32;
    localparam int FIFO_DEPTH = 4;
    localparam int MEM_WORDS  = 256;
    localparam int CLK_PERIOD = 4;
    localparam int N_IDENT    = 8;
    localparam int N_REG      = 40;
    localparam int N_WIN      = 6;
    localparam int N_BURST    = 60;
    localparam int N_OPS      = 4 + N_IDENT + 2 * N_REG + N_WIN * (4 + N_BURST);
    localparam int TIMEOUT_CYCLES = N_OPS * (FIFO_DEPTH + 4) + 100;

    logic                  clk, rst, ctrl_wen, ctrl_ren, req_valid, req_write, req_full;
    logic                  rsp_valid, rsp_write;
    logic [3:0]            ctrl_waddr, ctrl_raddr;
    logic [31:0]           ctrl_wdata, ctrl_rdata, req_wdata, rsp_rdata;
    logic [ADDR_WIDTH-1:0] req_addr, rsp_addr;
    int                    value_errors, other_errors, rsp_count;
    integer                seed = 10;
    int                    issued = 0;

    emu_remap_top #(.ADDR_WIDTH(ADDR_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .MEM_WORDS(MEM_WORDS))
        uut (.*);
    remap_checker #(.ADDR_WIDTH(ADDR_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .MEM_WORDS(MEM_WORDS))
        chk (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // strobes last one cycle unless set again after this.
    task automatic next_cycle();
        @(posedge clk);
        ctrl_wen  <= 1'b0;
        ctrl_ren  <= 1'b0;
        req_valid <= 1'b0;
    endtask

    task automatic put_ctrl_write(input logic [1:0] sel, input logic [31:0] data);
        ctrl_wen   <= 1'b1;
        ctrl_waddr <= {sel, 2'b00};
        ctrl_wdata <= data;
    endtask

    task automatic put_ctrl_read(input logic [1:0] sel);
        ctrl_ren   <= 1'b1;
        ctrl_raddr <= {sel, 2'b00};
    endtask

    task automatic put_random_request();
        logic [31:0] addr;
        logic [31:0] ctl;
        addr = $random(seed);
        ctl  = $random(seed);
        // few word indices, so reads often find earlier writes.
        addr[9:2] = {4'd0, ctl[3:0]};
        req_valid <= 1'b1;
        req_write <= ctl[4];
        req_addr  <= ADDR_WIDTH'(addr);
        req_wdata <= $random(seed);
        issued++;
    endtask

    task automatic send_burst(input int n, input bit rewrites);
        int          sent;
        logic [31:0] r;
        sent = 0;
        while (sent < n) begin
            next_cycle();
            r = $random(seed);
            if (!req_full && r[1:0] != 2'b00) begin
                put_random_request();
                sent++;
            end
            if (rewrites && r[7:4] == 4'd0) begin
                put_ctrl_write(r[9:8], $random(seed));
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        rst        <= 1'b1;
        ctrl_wen   <= 1'b0;
        ctrl_waddr <= '0;
        ctrl_wdata <= '0;
        ctrl_ren   <= 1'b0;
        ctrl_raddr <= '0;
        req_valid  <= 1'b0;
        req_write  <= 1'b0;
        req_addr   <= '0;
        req_wdata  <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < 4; s++) begin
            next_cycle();
            put_ctrl_read(2'(s));
        end
        send_burst(N_IDENT, 1'b0);
        for (int i = 0; i < N_REG; i++) begin
            r = $random(seed);
            next_cycle();
            put_ctrl_write(r[1:0], $random(seed));
            next_cycle();
            put_ctrl_read(r[1:0]);
        end
        // new window each round, later rounds rewrite it mid-burst.
        for (int w = 0; w < N_WIN; w++) begin
            for (int s = 0; s < 4; s++) begin
                next_cycle();
                put_ctrl_write(2'(s), $random(seed));
            end
            send_burst(N_BURST, w > 0);
        end
        next_cycle();
        wait (rsp_count == issued);
        repeat (4) next_cycle();
        $display("done: %0d value errors, %0d other errors, %0d of %0d responses",
                 value_errors, other_errors, rsp_count, issued);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles: %0d value errors, %0d other errors, %0d of %0d responses",
                 TIMEOUT_CYCLES, value_errors, other_errors, rsp_count, issued);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== remap_checker.sv ====
`timescale 1ns/1ps

module remap_checker #(
    parameter int ADDR_WIDTH = 32,
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ctrl_wen,
    input  logic [3:0]            ctrl_waddr,
    input  logic [31:0]           ctrl_wdata,
    input  logic                  ctrl_ren,
    input  logic [3:0]            ctrl_raddr,
    input  logic [31:0]           ctrl_rdata,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [31:0]           req_wdata,
    input  logic                  req_full,
    input  logic                  rsp_valid,
    input  logic                  rsp_write,
    input  logic [ADDR_WIDTH-1:0] rsp_addr,
    input  logic [31:0]           rsp_rdata,
    output int                    value_errors,
    output int                    other_errors,
    output int                    rsp_count
);
    import emu_remap_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    // low twelve bits stay fixed in the model by construction.
    logic [63:0] base_m = '0;
    logic [63:0] mask_m = '1;
    logic [31:0] mem_m [MEM_WORDS] = '{default: '0};
    remap_req_t  exp_q [$];
    logic        last_rsp = 1'b0;
    logic        last_req = 1'b0;
    int          n_value = 0;
    int          n_other = 0;
    int          n_rsp = 0;

    assign value_errors = n_value;
    assign other_errors = n_other;
    assign rsp_count    = n_rsp;

    function automatic logic [31:0] readback(input logic [1:0] sel);
        case (reg_sel_e'(sel))
            SEL_BASE_LO: return base_m[31:0];
            SEL_BASE_HI: return base_m[63:32];
            SEL_MASK_LO: return mask_m[31:0];
            default:     return mask_m[63:32];
        endcase
    endfunction

    task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
        if (want !== got) begin
            $display("ERROR at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
            n_value++;
        end
    endtask

    task automatic check_response();
        remap_req_t       want;
        logic [IDX_W-1:0] idx;
        n_rsp++;
        if (exp_q.size() == 0) begin
            $display("response at time %0t arrived with no request waiting for it", $time);
            n_other++;
            return;
        end
        want = exp_q.pop_front();
        idx  = want.addr[IDX_W+1:2];
        compare("rsp_write", 64'(want.write), 64'(rsp_write));
        compare("rsp_addr", want.addr, 64'(rsp_addr));
        compare("rsp_rdata", want.write ? 64'd0 : 64'(mem_m[idx]), 64'(rsp_rdata));
        if (want.write) begin
            mem_m[idx] = want.wdata;
        end
    endtask

    // inputs sampled here were driven on the previous edge.
    always @(posedge clk) begin
        logic [63:0] mapped;
        remap_req_t  item;
        int          occ;
        if (rst) begin
            base_m = '0;
            mask_m = '1;
            exp_q.delete();
            last_rsp = 1'b0;
            last_req = 1'b0;
        end else begin
            // unanswered requests, less the one still in the producer register
            // and the one whose pop took place on the last edge.
            occ = exp_q.size() - int'(last_req) - int'(rsp_valid);
            compare("req_full", 64'(occ >= FIFO_DEPTH - 1), 64'(req_full));
            if (ctrl_ren) begin
                compare("ctrl_rdata", 64'(readback(ctrl_raddr[3:2])), 64'(ctrl_rdata));
            end
            // remap with the registers in force before this edge's write.
            if (req_valid) begin
                mapped     = (64'(req_addr) & mask_m) | (base_m & ~mask_m);
                item.write = req_write;
                item.addr  = 64'(mapped[ADDR_WIDTH-1:0]);
                item.wdata = req_wdata;
                exp_q.push_back(item);
            end
            if (ctrl_wen) begin
                case (reg_sel_e'(ctrl_waddr[3:2]))
                    SEL_BASE_LO: base_m[31:12] = ctrl_wdata[31:12];
                    SEL_BASE_HI: base_m[63:32] = ctrl_wdata;
                    SEL_MASK_LO: mask_m[31:12] = ctrl_wdata[31:12];
                    default:     mask_m[63:32] = ctrl_wdata;
                endcase
            end
            if (rsp_valid) begin
                check_response();
            end
            if (rsp_valid && last_rsp) begin
                $display("responses at time %0t came in two consecutive cycles", $time);
                n_other++;
            end
            last_rsp = rsp_valid;
            last_req = req_valid;
        end
    end

endmodule

// ==== remap_properties.sv ====
`timescale 1ns/1ps

module remap_properties #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        push_valid,
    input logic                        pop,
    input logic [$clog2(FIFO_DEPTH):0] count
);
    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> (count != CNT_W'(FIFO_DEPTH)))
        else $error("push arrived while the buffer held FIFO_DEPTH entries");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count != '0))
        else $error("pop taken from an empty buffer");

    // responses trail pops by one cycle, so pop spacing is response spacing.
    a_rsp_spacing: assert property (@(posedge clk) disable iff (rst)
        pop |=> !pop)
        else $error("pops in consecutive cycles give back to back responses");

endmodule

bind req_fifo remap_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) props (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push.valid),
    .pop        (pop_side.pop),
    .count      (count)
);

// ==== emu_remap_top.sv ====
`timescale 1ns/1ps

module emu_remap_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  ctrl_wen,
    input  logic [3:0]            ctrl_waddr,
    input  logic [31:0]           ctrl_wdata,
    input  logic                  ctrl_ren,
    input  logic [3:0]            ctrl_raddr,
    output logic [31:0]           ctrl_rdata,

    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [31:0]           req_wdata,
    output logic                  req_full,

    output logic                  rsp_valid,
    output logic                  rsp_write,
    output logic [ADDR_WIDTH-1:0] rsp_addr,
    output logic [31:0]           rsp_rdata
);

    logic [31:0] sel_rdata;

    remap_req_if push_if ();
    remap_req_if pop_if ();

    remap_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .ctrl_wen   (ctrl_wen),
        .ctrl_waddr (ctrl_waddr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_raddr (ctrl_raddr),
        .ctrl_rdata (sel_rdata),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .push       (push_if.source)
    );

    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push_if.store),
        .pop_side (pop_if.sink)
    );

    mem_window #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .pop_side  (pop_if.consumer),
        .rsp_valid (rsp_valid),
        .rsp_write (rsp_write),
        .rsp_addr  (rsp_addr),
        .rsp_rdata (rsp_rdata)
    );

    // readback is zero unless a read is strobed.
    assign ctrl_rdata = ctrl_ren ? sel_rdata : 32'd0;
    assign req_full   = push_if.full;

endmodule

// ==== mem_window.sv ====
`timescale 1ns/1ps

module mem_window #(
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_WORDS  = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    remap_req_if.consumer         pop_side,
    output logic                  rsp_valid,
    output logic                  rsp_write,
    output logic [ADDR_WIDTH-1:0] rsp_addr,
    output logic [31:0]           rsp_rdata
);
    import emu_remap_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic {
        ST_IDLE,
        ST_ACCESS
    } state_e;

    state_e           state;
    remap_req_t       head;
    logic [IDX_W-1:0] idx;
    logic             take;
    logic [31:0]      mem [MEM_WORDS];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign head = pop_side.req;
    assign idx  = head.addr[IDX_W+1:2];
    assign take = (state == ST_IDLE) && pop_side.valid;

    assign pop_side.pop = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= take;
            state     <= take ? ST_ACCESS : ST_IDLE;
        end
    end

    // access happens on the pop edge, response shows the cycle after.
    always_ff @(posedge clk) begin
        if (take) begin
            rsp_write <= head.write;
            rsp_addr  <= head.addr[ADDR_WIDTH-1:0];
            if (head.write) begin
                mem[idx]  <= head.wdata;
                rsp_rdata <= '0;
            end else begin
                rsp_rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    remap_req_if.store  push,
    remap_req_if.sink   pop_side
);
    import emu_remap_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    remap_req_t       entries [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a push into a truly full buffer is dropped.
    assign do_pop  = pop_side.pop && (count != '0);
    assign do_push = push.valid && ((count != CNT_W'(FIFO_DEPTH)) || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push.req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one entry of slack for the request in the producer register.
    assign push.full = (count >= CNT_W'(FIFO_DEPTH - 1));

    assign pop_side.valid = (count != '0);
    assign pop_side.req   = entries[rd_ptr];

endmodule

// ==== remap_ctrl.sv ====
`timescale 1ns/1ps

module remap_ctrl #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  ctrl_wen,
    input  logic [3:0]            ctrl_waddr,
    input  logic [31:0]           ctrl_wdata,
    input  logic [3:0]            ctrl_raddr,
    output logic [31:0]           ctrl_rdata,

    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [31:0]           req_wdata,

    remap_req_if.source           push
);
    import emu_remap_pkg::*;

    localparam int HI_BITS = 64 - PAGE_BITS;
    localparam int LO_PAGE = 32 - PAGE_BITS;

    logic [HI_BITS-1:0]    base_page;
    logic [HI_BITS-1:0]    mask_page;
    ctrl_word_u            wr_word;
    ctrl_word_u            rd_word;
    reg_sel_e              wsel;
    reg_sel_e              rsel;
    logic [63:0]           full_base;
    logic [63:0]           full_mask;
    logic [ADDR_WIDTH-1:0] win_base;
    logic [ADDR_WIDTH-1:0] win_mask;
    logic [63:0]           remapped;
    logic                  push_valid;
    remap_req_t            push_req;

    assign wr_word = ctrl_wdata;
    assign wsel    = reg_sel_e'(ctrl_waddr[3:2]);
    assign rsel    = reg_sel_e'(ctrl_raddr[3:2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            base_page <= '0;
            mask_page <= '1;
        end else if (ctrl_wen) begin
            case (wsel)
                SEL_BASE_LO: base_page[LO_PAGE-1:0]       <= wr_word.lo.page;
                SEL_BASE_HI: base_page[HI_BITS-1:LO_PAGE] <= wr_word.raw;
                SEL_MASK_LO: mask_page[LO_PAGE-1:0]       <= wr_word.lo.page;
                SEL_MASK_HI: mask_page[HI_BITS-1:LO_PAGE] <= wr_word.raw;
                default: ;
            endcase
        end
    end

    // page offset bits are fixed, zero in base and ones in mask.
    always_comb begin
        rd_word.raw = '0;
        case (rsel)
            SEL_BASE_LO: begin
                rd_word.lo.page   = base_page[LO_PAGE-1:0];
                rd_word.lo.offset = '0;
            end
            SEL_BASE_HI: rd_word.raw = base_page[HI_BITS-1:LO_PAGE];
            SEL_MASK_LO: begin
                rd_word.lo.page   = mask_page[LO_PAGE-1:0];
                rd_word.lo.offset = '1;
            end
            SEL_MASK_HI: rd_word.raw = mask_page[HI_BITS-1:LO_PAGE];
            default: ;
        endcase
    end

    assign ctrl_rdata = rd_word.raw;

    assign full_base = {base_page, {PAGE_BITS{1'b0}}};
    assign full_mask = {mask_page, {PAGE_BITS{1'b1}}};
    assign win_base  = full_base[ADDR_WIDTH-1:0];
    assign win_mask  = full_mask[ADDR_WIDTH-1:0];

    // kept bits from the request, the rest from the base.
    always_comb begin
        remapped = '0;
        remapped[ADDR_WIDTH-1:0] = (req_addr & win_mask) | (win_base & ~win_mask);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            push_req.write <= req_write;
            push_req.addr  <= remapped;
            push_req.wdata <= req_wdata;
        end
    end

    assign push.valid = push_valid;
    assign push.req   = push_req;

endmodule

// ==== remap_req_if.sv ====
`timescale 1ns/1ps

interface remap_req_if;
    import emu_remap_pkg::*;

    logic       valid;
    remap_req_t req;
    logic       full;
    logic       pop;

    // producer pushing into the buffer.
    modport source (
        output valid,
        output req,
        input  full
    );

    // buffer input side, seen from the buffer.
    modport store (
        input  valid,
        input  req,
        output full
    );

    // buffer output side.
    modport sink (
        output valid,
        output req,
        input  pop
    );

    // consumer taking entries from the buffer.
    modport consumer (
        input  valid,
        input  req,
        output pop
    );

endinterface

// ==== emu_remap_pkg.sv ====
package emu_remap_pkg;

    // page offset width, always kept by the mask.
    localparam int PAGE_BITS = 12;

    // register select from control address bits 3 to 2.
    typedef enum logic [1:0] {
        SEL_BASE_LO = 2'd0,
        SEL_BASE_HI = 2'd1,
        SEL_MASK_LO = 2'd2,
        SEL_MASK_HI = 2'd3
    } reg_sel_e;

    // low page part of a 64-bit window value.
    typedef struct packed {
        logic [31-PAGE_BITS:0] page;
        logic [PAGE_BITS-1:0]  offset;
    } ctrl_lo_t;

    // control data word, raw for high registers, split for low ones.
    typedef union packed {
        logic [31:0] raw;
        ctrl_lo_t    lo;
    } ctrl_word_u;

    // one remapped request.
    typedef struct packed {
        logic        write;
        logic [63:0] addr;
        logic [31:0] wdata;
    } remap_req_t;

endpackage
